// File: logic/avg_ctrl_pkg.sv
`default_nettype none

package avg_ctrl_pkg;

  parameter int LEN_W   = 12;  // Frame length
  parameter int K_W     = 4;   // Sweep count exponent
  parameter int SWEEP_W = 16;  // Sweep counters, up to 2**15 sweeps

  // Run configuration, latched on start
  typedef struct packed {
    logic [LEN_W-1:0] frame_len;    // 1 .. MAX_FRAME
    logic [K_W-1:0]   sweeps_log2;  // 2**k sweeps
  } avg_cfg_t;

endpackage

`default_nettype wire

// File: logic/avg_data_pkg.sv
`default_nettype none

package avg_data_pkg;

  parameter int SAMPLE_W = 16;
  parameter int ACC_W    = 32;  // Room for 2**15 full-scale sweeps

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [ACC_W-1:0]    acc_t;

  // Widened input sample
  typedef struct packed {
    acc_t data;
    logic first;  // First of sweep
  } sample_beat_t;

  // Final sum of one frame position
  typedef struct packed {
    acc_t data;
    logic last;   // Last of frame
  } sum_beat_t;

  // Scaled mean to the output stream
  typedef struct packed {
    sample_t data;
    logic    last;
  } result_beat_t;

endpackage

`default_nettype wire

// File: logic/result_framer.sv
`timescale 1ns/100ps
`default_nettype none

module result_framer
  import avg_data_pkg::*;
  import avg_ctrl_pkg::*;
(
  input  wire            aclk,
  input  wire            aresetn,
  input  wire avg_cfg_t  run_cfg,
  input  wire            run_start,
  input  wire sum_beat_t sum,
  input  wire            sum_valid,
  input  wire            out_full,
  output logic           out_wr,
  output result_beat_t   out_beat,
  output logic           overrun
);

  acc_t scaled;

  // Mean rounds toward minus infinity
  assign scaled = $signed(sum.data) >>> run_cfg.sweeps_log2;

  // ********************
  // Write strobe and overrun
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      out_wr  <= 1'b0;
      overrun <= 1'b0;
    end
    else
    begin
      out_wr <= sum_valid;
      if (run_start)
        overrun <= 1'b0;
      if (out_wr && out_full)
        overrun <= 1'b1;  // Beat dropped by the full FIFO
    end
  end

  always_ff @(posedge aclk)
  begin
    if (sum_valid)
    begin
      out_beat.data <= scaled[SAMPLE_W-1:0];
      out_beat.last <= sum.last;
    end
  end

endmodule

`default_nettype wire

// File: logic/sweep_accumulator.sv
`timescale 1ns/100ps
`default_nettype none

module sweep_accumulator
  import avg_data_pkg::*;
  import avg_ctrl_pkg::*;
#(
  parameter int MAX_FRAME = 1024
)
(
  input  wire               aclk,
  input  wire               aresetn,
  input  wire avg_cfg_t     run_cfg,
  input  wire sample_beat_t samp,
  input  wire               samp_valid,
  input  wire acc_t         fifo_head,
  input  wire               fifo_empty,
  output acc_t              fifo_wdata,
  output logic              fifo_wr,
  output logic              fifo_rd,
  output sum_beat_t         sum,
  output logic              sum_valid
);

  localparam int POS_W = (MAX_FRAME > 1) ? $clog2(MAX_FRAME) : 1;

  logic               in_run;
  logic [POS_W-1:0]   pos_cnt;
  logic [SWEEP_W-1:0] sweep_cnt;
  logic [POS_W-1:0]   cur_pos;
  logic [SWEEP_W-1:0] cur_sweep;
  logic               first_sweep;
  logic               last_sweep;
  logic               last_pos;
  acc_t               acc_base;
  acc_t               acc_next;
  acc_t               sum_q;
  logic               valid_q;
  logic               final_q;
  logic               last_q;

  // A first flag outside a run begins sweep zero
  assign cur_pos     = samp.first ? '0 : pos_cnt;
  assign cur_sweep   = in_run ? sweep_cnt : '0;
  assign first_sweep = (cur_sweep == '0);
  assign last_sweep  = (cur_sweep ==
                        (SWEEP_W'(1) << run_cfg.sweeps_log2) - SWEEP_W'(1));
  assign last_pos    = (LEN_W'(cur_pos) == run_cfg.frame_len - LEN_W'(1));

  assign acc_base = (first_sweep || fifo_empty) ? '0 : fifo_head;
  assign acc_next = acc_base + samp.data;

  assign fifo_rd = samp_valid && !first_sweep;  // Show-ahead, consumed now

  // ********************
  // Position and sweep counters
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      in_run    <= 1'b0;
      pos_cnt   <= '0;
      sweep_cnt <= '0;
      valid_q   <= 1'b0;
    end
    else
    begin
      valid_q <= samp_valid;
      if (samp_valid)
      begin
        if (last_pos)
        begin
          pos_cnt <= '0;
          if (last_sweep)
          begin
            in_run    <= 1'b0;
            sweep_cnt <= '0;
          end
          else
          begin
            in_run    <= 1'b1;
            sweep_cnt <= cur_sweep + SWEEP_W'(1);
          end
        end
        else
        begin
          in_run    <= 1'b1;
          pos_cnt   <= cur_pos + POS_W'(1);
          sweep_cnt <= cur_sweep;
        end
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (samp_valid)
    begin
      sum_q   <= acc_next;
      final_q <= last_sweep;
      last_q  <= last_pos;
    end
  end

  // Recirculate, or hand out in the last sweep
  assign fifo_wdata = sum_q;
  assign fifo_wr    = valid_q && !final_q;
  assign sum.data   = sum_q;
  assign sum.last   = last_q;
  assign sum_valid  = valid_q && final_q;

endmodule

`default_nettype wire

// File: logic/sweep_capture.sv
`timescale 1ns/100ps
`default_nettype none

module sweep_capture
  import avg_data_pkg::*;
  import avg_ctrl_pkg::*;
(
  input  wire               aclk,
  input  wire               aresetn,
  input  wire               start,
  input  wire avg_cfg_t     cfg,
  input  wire               trigger,
  input  wire               adc_valid,
  input  wire sample_t      adc_data,
  output avg_cfg_t          run_cfg,
  output logic              run_start,
  output sample_beat_t      samp,
  output logic              samp_valid,
  output logic              busy
);

  logic               win_open;
  logic [LEN_W-1:0]   pos_cnt;
  logic [SWEEP_W-1:0] sweep_cnt;
  logic               last_pos;
  logic               last_sweep;

  assign last_pos   = (pos_cnt == run_cfg.frame_len - LEN_W'(1));
  assign last_sweep = (sweep_cnt ==
                       (SWEEP_W'(1) << run_cfg.sweeps_log2) - SWEEP_W'(1));

  // ********************
  // Run and window control
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      run_cfg    <= '0;
      run_start  <= 1'b0;
      busy       <= 1'b0;
      win_open   <= 1'b0;
      samp_valid <= 1'b0;
      pos_cnt    <= '0;
      sweep_cnt  <= '0;
    end
    else
    begin
      run_start  <= 1'b0;
      samp_valid <= 1'b0;
      if (start && !busy)
      begin
        run_cfg   <= cfg;
        run_start <= 1'b1;
        busy      <= 1'b1;  // Armed, waiting for trigger
        sweep_cnt <= '0;
      end
      else if (busy && !win_open && trigger)
      begin
        win_open <= 1'b1;
        pos_cnt  <= '0;
      end
      else if (win_open && adc_valid)
      begin
        samp_valid <= 1'b1;
        pos_cnt    <= pos_cnt + LEN_W'(1);
        if (last_pos)
        begin
          win_open  <= 1'b0;
          sweep_cnt <= sweep_cnt + SWEEP_W'(1);
          if (last_sweep)
            busy <= 1'b0;  // Run complete
        end
      end
    end
  end

  // ********************
  // Sample widening
  always_ff @(posedge aclk)
  begin
    if (win_open && adc_valid)
    begin
      samp.data  <= {{(ACC_W-SAMPLE_W){adc_data[SAMPLE_W-1]}}, adc_data};
      samp.first <= (pos_cnt == '0);
    end
  end

endmodule

`default_nettype wire

// File: logic/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 16
)
(
  input  wire           aclk,
  input  wire           aresetn,
  input  wire           wr,
  input  wire payload_t wdata,
  input  wire           rd,
  output payload_t      head,
  output logic          empty,
  output logic          full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            do_wr;
  logic            do_rd;

  assign empty = (count == '0);
  assign full  = (count == CW'(DEPTH));
  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;

  assign head = mem[rd_ptr];  // Oldest entry

  // ********************
  // Pointers and occupancy
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
      if (do_rd)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
      case ({do_wr, do_rd})
        2'b10:   count <= count + CW'(1);
        2'b01:   count <= count - CW'(1);
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge aclk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wdata;
  end

endmodule

`default_nettype wire

// File: logic/trace_averager.sv
`timescale 1ns/100ps
`default_nettype none

module trace_averager
  import avg_data_pkg::*;
  import avg_ctrl_pkg::*;
#(
  parameter int MAX_FRAME = 1024,
  parameter int OUT_DEPTH = 16
)
(
  input  wire           aclk,
  input  wire           aresetn,
  input  wire           start,
  input  wire avg_cfg_t cfg,
  input  wire           trigger,
  input  wire           adc_valid,
  input  wire sample_t  adc_data,
  output result_beat_t  result,
  output logic          result_valid,
  input  wire           result_ready,
  output logic          busy,
  output logic          overrun
);

  avg_cfg_t     run_cfg;
  logic         run_start;
  sample_beat_t samp;
  logic         samp_valid;

  acc_t         recirc_head;
  logic         recirc_empty;
  acc_t         recirc_wdata;
  logic         recirc_wr;
  logic         recirc_rd;

  sum_beat_t    sum;
  logic         sum_valid;

  logic         out_wr;
  result_beat_t out_beat;
  logic         out_full;
  logic         out_empty;

  assign result_valid = !out_empty;

  // ********************
  // Input side and core
  sweep_capture sweep_capture_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .start      (start),
    .cfg        (cfg),
    .trigger    (trigger),
    .adc_valid  (adc_valid),
    .adc_data   (adc_data),
    .run_cfg    (run_cfg),
    .run_start  (run_start),
    .samp       (samp),
    .samp_valid (samp_valid),
    .busy       (busy)
  );

  sweep_accumulator #(.MAX_FRAME(MAX_FRAME)) sweep_accumulator_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .run_cfg    (run_cfg),
    .samp       (samp),
    .samp_valid (samp_valid),
    .fifo_head  (recirc_head),
    .fifo_empty (recirc_empty),
    .fifo_wdata (recirc_wdata),
    .fifo_wr    (recirc_wr),
    .fifo_rd    (recirc_rd),
    .sum        (sum),
    .sum_valid  (sum_valid)
  );

  // Partial sums, one per frame position
  sync_fifo #(.payload_t(acc_t), .DEPTH(MAX_FRAME)) recirc_fifo_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr      (recirc_wr),
    .wdata   (recirc_wdata),
    .rd      (recirc_rd),
    .head    (recirc_head),
    .empty   (recirc_empty),
    .full    ()
  );

  // ********************
  // Output side
  result_framer result_framer_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .run_cfg   (run_cfg),
    .run_start (run_start),
    .sum       (sum),
    .sum_valid (sum_valid),
    .out_full  (out_full),
    .out_wr    (out_wr),
    .out_beat  (out_beat),
    .overrun   (overrun)
  );

  sync_fifo #(.payload_t(result_beat_t), .DEPTH(OUT_DEPTH)) out_fifo_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr      (out_wr),
    .wdata   (out_beat),
    .rd      (result_valid && result_ready),  // Pop on transfer
    .head    (result),
    .empty   (out_empty),
    .full    (out_full)
  );

endmodule

`default_nettype wire

// File: testbench/trace_averager_properties.sv
`timescale 1ns/100ps
`default_nettype none

module trace_averager_properties (
  input wire aclk,
  input wire aresetn,
  input wire samp_valid,
  input wire samp_first,
  input wire fifo_empty,
  input wire fifo_rd,
  input wire sum_valid,
  input wire sum_last
);

  int n_fail = 0;  // Failed assertions

  // ********************
  // Recirculation FIFO use
  no_read_on_empty: assert property (
    @(posedge aclk) disable iff (!aresetn) fifo_rd |-> !fifo_empty)
    else
    begin
      $error("recirculation FIFO read while empty");
      n_fail++;
    end

  // Last sweep has consumed every partial sum
  drained_at_frame_end: assert property (
    @(posedge aclk) disable iff (!aresetn) sum_valid && sum_last |-> fifo_empty)
    else
    begin
      $error("partial sums left in the FIFO after the last frame position");
      n_fail++;
    end

  // A new run finds no stale partial sums
  empty_at_run_start: assert property (
    @(posedge aclk) disable iff (!aresetn)
    samp_valid && samp_first && !fifo_rd |-> fifo_empty)
    else
    begin
      $error("recirculation FIFO not empty at the start of sweep zero");
      n_fail++;
    end

endmodule

bind sweep_accumulator trace_averager_properties props_i (
  .aclk       (aclk),
  .aresetn    (aresetn),
  .samp_valid (samp_valid),
  .samp_first (samp.first),
  .fifo_empty (fifo_empty),
  .fifo_rd    (fifo_rd),
  .sum_valid  (sum_valid),
  .sum_last   (sum.last)
);

`default_nettype wire

// File: testbench/trace_averager_tb.sv
`timescale 1ns/100ps
`default_nettype none

module trace_averager_tb
  import avg_data_pkg::*;
  import avg_ctrl_pkg::*;
;

  localparam int MAX_FRAME = 64;
  localparam int OUT_DEPTH = 16;
  localparam int N_CASES   = 7;
  localparam int STIM_MAX  = 1024;

  localparam logic [1:0] RDY_ON   = 2'd0;
  localparam logic [1:0] RDY_RAND = 2'd1;
  localparam logic [1:0] RDY_LOW  = 2'd2;  // Held low until the run is over

  typedef struct packed {
    logic [LEN_W-1:0] frame_len;
    logic [3:0]       k;
    logic             gaps;  // Idle cycles, stray samples and triggers
    logic [1:0]       ready_mode;
    logic             exp_overrun;
  } case_row_t;

  localparam case_row_t ROWS [N_CASES] = '{
    '{12'd8,  4'd0, 1'b0, RDY_ON,   1'b0},  // Single sweep
    '{12'd1,  4'd2, 1'b0, RDY_ON,   1'b0},
    '{12'd13, 4'd1, 1'b1, RDY_ON,   1'b0},
    '{12'd64, 4'd4, 1'b0, RDY_ON,   1'b0},  // Full frame
    '{12'd20, 4'd3, 1'b1, RDY_RAND, 1'b0},
    '{12'd24, 4'd1, 1'b0, RDY_LOW,  1'b1},  // More beats than OUT_DEPTH
    '{12'd5,  4'd2, 1'b1, RDY_ON,   1'b0}
  };

  logic         aclk = 1'b0;
  logic         aresetn;
  logic         start;
  avg_cfg_t     cfg;
  logic         trigger;
  logic         adc_valid;
  sample_t      adc_data;
  result_beat_t result;
  logic         result_valid;
  logic         result_ready;
  logic         busy;
  logic         overrun;

  logic [31:0]  lcg_state = 32'h04e2_66a8;
  logic [1:0]   ready_mode;
  sample_t      stim_mem [STIM_MAX];
  longint       pos_sum [MAX_FRAME];
  result_beat_t exp_q [$];
  result_beat_t popped;
  int           n_checks = 0;
  int           n_errors = 0;
  int           n_beats  = 0;

  trace_averager #(.MAX_FRAME(MAX_FRAME), .OUT_DEPTH(OUT_DEPTH)) trace_averager_i (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .start        (start),
    .cfg          (cfg),
    .trigger      (trigger),
    .adc_valid    (adc_valid),
    .adc_data     (adc_data),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .busy         (busy),
    .overrun      (overrun)
  );

  always #10 aclk = ~aclk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Advance to the next falling edge, redraw a random ready
  task automatic next_cycle();
    logic [31:0] r;
    @(negedge aclk);
    if (ready_mode == RDY_RAND)
    begin
      r = next_rand();
      result_ready = (r[17:16] != 2'b00);
    end
  endtask

  // ********************
  // Compare tasks
  task automatic check_beat(input result_beat_t got, input result_beat_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      if (got.data !== exp.data)
        $display("error: result.data got %h expected %h", got.data, exp.data);
      if (got.last !== exp.last)
        $display("error: result.last got %h expected %h", got.last, exp.last);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // ********************
  // One table row
  task automatic run_case(input int idx);
    case_row_t    row;
    avg_cfg_t     run;
    result_beat_t eb;
    logic [31:0]  r;
    longint       mean;
    int           len;
    int           n_sweeps;
    int           err_start;
    int           beat_start;
    row        = ROWS[idx];
    len        = int'(row.frame_len);
    n_sweeps   = 1 << row.k;
    err_start  = n_errors;
    beat_start = n_beats;
    run.frame_len   = row.frame_len;
    run.sweeps_log2 = row.k;
    for (int p = 0; p < len; p++)
      pos_sum[p] = 0;
    for (int s = 0; s < n_sweeps; s++)
      for (int p = 0; p < len; p++)
      begin
        r = next_rand();
        stim_mem[s*len+p] = sample_t'(r[31:16]);
        pos_sum[p] += longint'(stim_mem[s*len+p]);
      end
    for (int p = 0; p < len; p++)
    begin
      mean    = pos_sum[p] >>> row.k;  // Floor of the mean
      eb.data = sample_t'(mean);
      eb.last = (p == len - 1);
      if (row.ready_mode != RDY_LOW || p < OUT_DEPTH)
        exp_q.push_back(eb);
    end
    ready_mode   = row.ready_mode;
    result_ready = (row.ready_mode != RDY_LOW);
    check_flag("busy", busy, 1'b0);
    start = 1'b1;
    cfg   = run;
    next_cycle();
    start = 1'b0;
    check_flag("busy", busy, 1'b1);
    next_cycle();
    check_flag("overrun", overrun, 1'b0);
    for (int s = 0; s < n_sweeps; s++)
    begin
      if (row.gaps)
      begin
        if (s == 0)
        begin
          start = 1'b1;  // Busy, so this config is not taken
          cfg   = '{frame_len: LEN_W'(3), sweeps_log2: 4'd0};
        end
        adc_valid = 1'b1;
        adc_data  = 16'sh7fff;  // Outside any window
        next_cycle();
        start = 1'b0;
        next_cycle();
      end
      trigger   = 1'b1;
      adc_valid = row.gaps;
      next_cycle();
      trigger   = 1'b0;
      adc_valid = 1'b0;
      for (int p = 0; p < len; p++)
      begin
        if (row.gaps)
        begin
          r = next_rand();
          repeat (r[25:24]) next_cycle();
          trigger = (p > 0 && p < len - 1);  // Inside the window
        end
        adc_valid = 1'b1;
        adc_data  = stim_mem[s*len+p];
        if (s == n_sweeps - 1 && p == len - 1)
          check_flag("busy", busy, 1'b1);
        next_cycle();
        adc_valid = 1'b0;
        trigger   = 1'b0;
      end
    end
    check_flag("busy", busy, 1'b0);
    repeat (6) next_cycle();
    check_flag("overrun", overrun, row.exp_overrun);
    ready_mode   = RDY_ON;
    result_ready = 1'b1;
    while (exp_q.size() > 0)
      next_cycle();
    repeat (3) next_cycle();
    check_flag("result_valid", result_valid, 1'b0);
    $display("case %0d: L=%0d k=%0d beats=%0d errors=%0d", idx, len, row.k,
             n_beats - beat_start, n_errors - err_start);
  endtask

  // Collector
  always @(posedge aclk)
  begin
    if (aresetn && result_valid && result_ready)
    begin
      if (exp_q.size() == 0)
      begin
        n_errors++;
        $display("a result beat arrived when none was expected");
      end
      else
      begin
        popped = exp_q.pop_front();
        check_beat(result, popped);
        n_beats++;
      end
    end
  end

  // ********************
  // Watchdog
  initial
  begin
    int total_cycles;
    total_cycles = 0;
    for (int i = 0; i < N_CASES; i++)
      total_cycles += int'(ROWS[i].frame_len) << ROWS[i].k;
    total_cycles = total_cycles * 8 + 1000;
    repeat (total_cycles) @(posedge aclk);
    $display("timeout: the run did not finish within %0d cycles", total_cycles);
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    aresetn      = 1'b0;
    start        = 1'b0;
    cfg          = '0;
    trigger      = 1'b0;
    adc_valid    = 1'b0;
    adc_data     = '0;
    result_ready = 1'b0;
    ready_mode   = RDY_ON;
    repeat (3) @(negedge aclk);
    aresetn = 1'b1;
    next_cycle();
    check_flag("busy", busy, 1'b0);
    check_flag("result_valid", result_valid, 1'b0);
    check_flag("overrun", overrun, 1'b0);
    for (int i = 0; i < N_CASES; i++)
      run_case(i);
    n_errors += trace_averager_i.sweep_accumulator_i.props_i.n_fail;
    $display("checks=%0d beats=%0d errors=%0d", n_checks, n_beats, n_errors);
    if (n_errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: trace_averager.f
logic/avg_data_pkg.sv
logic/avg_ctrl_pkg.sv
logic/sync_fifo.sv
logic/sweep_capture.sv
logic/sweep_accumulator.sv
logic/result_framer.sv
logic/trace_averager.sv
testbench/trace_averager_properties.sv
testbench/trace_averager_tb.sv
